// File: src/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// number of sets per way
`define DC_SETS 8

// set index width, log2 of DC_SETS
`define DC_IDX_W 3

// tag width, what is left of the address above index and offsets
`define DC_TAG_W 26

`define DC_WORD_W 32

// hit count goes here on halt
`define DC_HITCNT_ADDR 32'h3100

`endif

// File: src/cacheAddrPkg.sv
`default_nettype none
`include "dcache_params.svh"

package cacheAddrPkg;

   typedef logic [`DC_WORD_W-1:0] wordT;

   typedef logic [`DC_TAG_W-1:0] tagT;

   typedef logic [`DC_IDX_W-1:0] setIdxT;

   // byte address as the cache splits it
   typedef struct packed {
      tagT tag;
      setIdxT idx;
      logic blkOff;            // word within block
      logic [1:0] byteOff;
   } addrT;

   typedef wordT [1:0] blockT; // word 0 in low half

endpackage

`default_nettype wire

// File: src/cacheCtrlPkg.sv
`default_nettype none

package cacheCtrlPkg;
   import cacheAddrPkg::*;

   // one tag entry per set per way
   typedef struct packed {
      logic valid;
      logic dirty;
      tagT tag;
   } tagEntryT;

   typedef enum logic [3:0] {
      IDLE,
      WB0,         // victim word 0 out
      WB1,
      FILL0,       // new block word 0 in
      FILL1,
      INSTALL,
      WRHIT,
      DONE,
      HITCNT,
      FLUSH0,
      FLUSH1,
      FLUSHNEXT,
      FLUSHED
   } cacheStateT;

endpackage

`default_nettype wire

// File: src/setStore.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module setStore
   import cacheAddrPkg::*;
#(
   parameter type entryT = blockT
)
(
   input  logic   CLK,
   input  logic   nRST,
   input  setIdxT rdIdx,
   output entryT  rdEntry,
   input  logic   wrEn,
   input  setIdxT wrIdx,
   input  entryT  wrEntry
);

   entryT entries [`DC_SETS];

   // read port is combinational
   assign rdEntry = entries[rdIdx];

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         for (int i = 0; i < `DC_SETS; i++)
            entries[i] <= '0;
      end
      else if (wrEn)
      begin
         entries[wrIdx] <= wrEntry;
      end
   end

endmodule

`default_nettype wire

// File: src/hitLookup.sv
`timescale 1ns/1ps
`default_nettype none

module hitLookup
   import cacheAddrPkg::*;
   import cacheCtrlPkg::*;
(
   input  addrT     cpuAddr,
   input  logic     cpuWen,
   input  logic     inDone,
   input  tagEntryT tag0,
   input  tagEntryT tag1,
   input  blockT    data0,
   input  blockT    data1,
   output logic     hitAny,
   output logic     hitWay,
   output logic     cpuHit,
   output wordT     cpuLoad
);

   logic match0;
   logic match1;
   blockT hitBlock;

   assign match0 = tag0.valid && (tag0.tag == cpuAddr.tag);
   assign match1 = tag1.valid && (tag1.tag == cpuAddr.tag);

   assign hitAny = match0 || match1;
   assign hitWay = match1;          // a tag lives in one way only

   assign hitBlock = hitWay ? data1 : data0;
   assign cpuLoad = hitBlock[cpuAddr.blkOff];

   // writes only answer once the merge is in the array
   assign cpuHit = hitAny && (!cpuWen || inDone);

endmodule

`default_nettype wire

// File: src/missController.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module missController
   import cacheAddrPkg::*;
   import cacheCtrlPkg::*;
(
   input  logic     CLK,
   input  logic     nRST,
   input  logic     cpuRen,
   input  logic     cpuWen,
   input  logic     halt,
   input  addrT     cpuAddr,
   input  wordT     cpuStore,
   input  logic     hitAny,
   input  logic     hitWay,
   input  tagEntryT tag0,
   input  tagEntryT tag1,
   input  blockT    data0,
   input  blockT    data1,
   output setIdxT   rdIdx,
   output logic     tagWr0,
   output logic     tagWr1,
   output logic     dataWr0,
   output logic     dataWr1,
   output tagEntryT tagNew,
   output blockT    dataNew,
   output logic     inDone,
   output logic     flushed,
   output logic     memRen,
   output logic     memWen,
   output addrT     memAddr,
   output wordT     memStore,
   input  wordT     memLoad,
   input  logic     memWait
);

   // flush walks way 0 then way 1, all sets each
   localparam logic [`DC_IDX_W:0] lastFlush = {1'b1, `DC_IDX_W'(`DC_SETS - 1)};

   cacheStateT state;
   cacheStateT nextState;
   logic [`DC_SETS-1:0] lru;        // way to evict next
   wordT hitCnt;
   logic [`DC_IDX_W:0] flushCnt;    // {way, set}
   blockT fillBuf;

   setIdxT reqIdx;
   setIdxT flushIdx;
   logic reqValid;
   logic victimWay;
   tagEntryT victimTag;
   blockT victimData;
   logic flushWay;
   tagEntryT flushTag;
   blockT flushData;
   logic inFlush;

   assign reqIdx = cpuAddr.idx;
   assign reqValid = cpuRen || cpuWen;

   assign victimWay = lru[reqIdx];
   assign victimTag = victimWay ? tag1 : tag0;
   assign victimData = victimWay ? data1 : data0;

   assign flushIdx = flushCnt[`DC_IDX_W-1:0];
   assign flushWay = flushCnt[`DC_IDX_W];
   assign flushTag = flushWay ? tag1 : tag0;
   assign flushData = flushWay ? data1 : data0;

   assign inFlush = (state == FLUSH0) || (state == FLUSH1) || (state == FLUSHNEXT);
   assign rdIdx = inFlush ? flushIdx : reqIdx;

   assign inDone = (state == DONE);
   assign flushed = (state == FLUSHED);

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state <= IDLE;
         lru <= '0;
         hitCnt <= '0;
         flushCnt <= '0;
      end
      else
      begin
         state <= nextState;
         if (state == IDLE && reqValid && hitAny)
         begin
            hitCnt <= hitCnt + 1'b1;
            lru[reqIdx] <= ~hitWay;      // other way is now the older one
         end
         else if (state == INSTALL)
         begin
            lru[reqIdx] <= ~victimWay;
         end
         if (state == FLUSHNEXT)
            flushCnt <= flushCnt + 1'b1;
      end
   end

   // fill words, store word merged in on a write miss
   always_ff @(posedge CLK)
   begin
      if (state == FILL0 && !memWait)
         fillBuf[0] <= (cpuWen && !cpuAddr.blkOff) ? cpuStore : memLoad;
      if (state == FILL1 && !memWait)
         fillBuf[1] <= (cpuWen && cpuAddr.blkOff) ? cpuStore : memLoad;
   end

   always_comb
   begin
      nextState = state;
      case (state)
         IDLE:
         begin
            if (reqValid)
            begin
               if (hitAny)
                  nextState = cpuWen ? WRHIT : IDLE;
               else if (victimTag.dirty)
                  nextState = WB0;
               else
                  nextState = FILL0;
            end
            else if (halt)
            begin
               nextState = HITCNT;
            end
         end
         WB0:
            if (!memWait)
               nextState = WB1;
         WB1:
            if (!memWait)
               nextState = FILL0;
         FILL0:
            if (!memWait)
               nextState = FILL1;
         FILL1:
            if (!memWait)
               nextState = INSTALL;
         INSTALL:
            nextState = DONE;
         WRHIT:
            nextState = DONE;
         DONE:
            nextState = IDLE;
         HITCNT:
            if (!memWait)
               nextState = FLUSH0;
         FLUSH0:
         begin
            if (!flushTag.dirty)
               nextState = FLUSHNEXT;      // clean, nothing to write
            else if (!memWait)
               nextState = FLUSH1;
         end
         FLUSH1:
            if (!memWait)
               nextState = FLUSHNEXT;
         FLUSHNEXT:
            nextState = (flushCnt == lastFlush) ? FLUSHED : FLUSH0;
         FLUSHED:
            nextState = FLUSHED;         // held until reset
         default:
            nextState = IDLE;
      endcase
   end

   always_comb
   begin
      memRen = 1'b0;
      memWen = 1'b0;
      memAddr = '0;
      memStore = '0;
      tagWr0 = 1'b0;
      tagWr1 = 1'b0;
      dataWr0 = 1'b0;
      dataWr1 = 1'b0;
      tagNew = '0;
      dataNew = '0;
      case (state)
         WB0:
         begin
            memWen = 1'b1;
            memAddr = {victimTag.tag, reqIdx, 1'b0, 2'b00};
            memStore = victimData[0];
         end
         WB1:
         begin
            memWen = 1'b1;
            memAddr = {victimTag.tag, reqIdx, 1'b1, 2'b00};
            memStore = victimData[1];
         end
         FILL0:
         begin
            memRen = 1'b1;
            memAddr = {cpuAddr.tag, reqIdx, 1'b0, 2'b00};
         end
         FILL1:
         begin
            memRen = 1'b1;
            memAddr = {cpuAddr.tag, reqIdx, 1'b1, 2'b00};
         end
         INSTALL:
         begin
            tagWr0 = !victimWay;
            tagWr1 = victimWay;
            dataWr0 = !victimWay;
            dataWr1 = victimWay;
            tagNew = '{valid: 1'b1, dirty: cpuWen, tag: cpuAddr.tag};
            dataNew = fillBuf;
         end
         WRHIT:
         begin
            tagWr0 = !hitWay;
            tagWr1 = hitWay;
            dataWr0 = !hitWay;
            dataWr1 = hitWay;
            tagNew = '{valid: 1'b1, dirty: 1'b1, tag: cpuAddr.tag};
            dataNew = hitWay ? data1 : data0;
            dataNew[cpuAddr.blkOff] = cpuStore;
         end
         HITCNT:
         begin
            memWen = 1'b1;
            memAddr = addrT'(`DC_HITCNT_ADDR);
            memStore = hitCnt;
         end
         FLUSH0:
         begin
            if (flushTag.dirty)
            begin
               memWen = 1'b1;
               memAddr = {flushTag.tag, flushIdx, 1'b0, 2'b00};
               memStore = flushData[0];
            end
         end
         FLUSH1:
         begin
            memWen = 1'b1;
            memAddr = {flushTag.tag, flushIdx, 1'b1, 2'b00};
            memStore = flushData[1];
         end
         default:
         begin
            memRen = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: src/dcacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTop
   import cacheAddrPkg::*;
   import cacheCtrlPkg::*;
(
   input  logic CLK,
   input  logic nRST,
   input  logic cpuRen,
   input  logic cpuWen,
   input  logic halt,
   input  addrT cpuAddr,
   input  wordT cpuStore,
   output logic cpuHit,
   output wordT cpuLoad,
   output logic flushed,
   output logic memRen,
   output logic memWen,
   output addrT memAddr,
   output wordT memStore,
   input  wordT memLoad,
   input  logic memWait
);

   setIdxT rdIdx;
   tagEntryT tag0;
   tagEntryT tag1;
   blockT data0;
   blockT data1;
   tagEntryT tagNew;
   blockT dataNew;
   logic tagWr0;
   logic tagWr1;
   logic dataWr0;
   logic dataWr1;
   logic hitAny;
   logic hitWay;
   logic inDone;

   setStore #(.entryT(tagEntryT)) tagWay0 (
      .CLK, .nRST, .rdIdx, .rdEntry(tag0),
      .wrEn(tagWr0), .wrIdx(rdIdx), .wrEntry(tagNew)
   );

   setStore #(.entryT(tagEntryT)) tagWay1 (
      .CLK, .nRST, .rdIdx, .rdEntry(tag1),
      .wrEn(tagWr1), .wrIdx(rdIdx), .wrEntry(tagNew)
   );

   setStore #(.entryT(blockT)) dataWay0 (
      .CLK, .nRST, .rdIdx, .rdEntry(data0),
      .wrEn(dataWr0), .wrIdx(rdIdx), .wrEntry(dataNew)
   );

   setStore #(.entryT(blockT)) dataWay1 (
      .CLK, .nRST, .rdIdx, .rdEntry(data1),
      .wrEn(dataWr1), .wrIdx(rdIdx), .wrEntry(dataNew)
   );

   hitLookup lookup (
      .cpuAddr, .cpuWen, .inDone,
      .tag0, .tag1, .data0, .data1,
      .hitAny, .hitWay, .cpuHit, .cpuLoad
   );

   missController ctrl (
      .CLK, .nRST,
      .cpuRen, .cpuWen, .halt, .cpuAddr, .cpuStore,
      .hitAny, .hitWay,
      .tag0, .tag1, .data0, .data1,
      .rdIdx,
      .tagWr0, .tagWr1, .dataWr0, .dataWr1,
      .tagNew, .dataNew,
      .inDone, .flushed,
      .memRen, .memWen, .memAddr, .memStore,
      .memLoad, .memWait
   );

endmodule

`default_nettype wire

// File: dv/clkGen.sv
`timescale 1ns/1ps
`default_nettype none

module clkGen
(
   output logic CLK,
   output logic nRST
);

   initial
   begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;   // 8 ns period
   end

   initial
   begin
      nRST = 1'b0;
      repeat (16) @(posedge CLK);
      @(negedge CLK);          // release away from the active edge
      nRST = 1'b1;
   end

endmodule

`default_nettype wire

// File: dv/memModel.sv
`timescale 1ns/1ps
`default_nettype none

module memModel
   import cacheAddrPkg::*;
(
   input  logic CLK,
   input  logic nRST,
   input  logic memRen,
   input  logic memWen,
   input  addrT memAddr,
   input  wordT memStore,
   output wordT memLoad,
   output logic memWait,
   input  addrT peekAddr,
   output wordT peekData
);

   wordT mem [logic [29:0]];    // only written words are stored
   logic [1:0] waitLeft;        // wait cycles before the next request completes
   integer seed;
   integer draw;

   initial seed = 17524;

   function automatic wordT readWord(input logic [29:0] wIdx);
      if (mem.exists(wIdx))
         return mem[wIdx];
      return {2'b00, wIdx} ^ 32'hA5A5_0000;   // untouched words follow the address
   endfunction

   assign memLoad = readWord(memAddr[31:2]);
   assign peekData = readWord(peekAddr[31:2]);
   assign memWait = (waitLeft != 2'd0);

   always @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         waitLeft <= 2'd0;
      end
      else if (memRen || memWen)
      begin
         if (waitLeft != 2'd0)
         begin
            waitLeft <= waitLeft - 2'd1;
         end
         else
         begin
            if (memWen)
               mem[memAddr[31:2]] = memStore;
            draw = $random(seed);
            waitLeft <= draw[1:0];       // wait for the next request
         end
      end
   end

endmodule

`default_nettype wire

// File: dv/dcacheTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcacheTb
   import cacheAddrPkg::*;
();

   logic CLK;
   logic nRST;
   logic cpuRen;
   logic cpuWen;
   logic halt;
   addrT cpuAddr;
   wordT cpuStore;
   logic cpuHit;
   wordT cpuLoad;
   logic flushed;
   logic memRen;
   logic memWen;
   addrT memAddr;
   wordT memStore;
   wordT memLoad;
   logic memWait;
   addrT peekAddr;
   wordT peekData;

   wordT shadow [logic [29:0]];   // memory as the CPU should see it
   tagT refTag [2][`DC_SETS];
   logic refValid [2][`DC_SETS];
   logic refDirty [2][`DC_SETS];
   logic refLru [`DC_SETS];
   wordT refHits;
   logic halting;
   logic cntSeen;
   addrT wrQ [$];                 // committed memory writes
   logic [29:0] touched [$];
   integer seed;

   clkGen clocks (.CLK, .nRST);

   memModel mainMem (
      .CLK, .nRST, .memRen, .memWen, .memAddr, .memStore,
      .memLoad, .memWait, .peekAddr, .peekData
   );

   dcacheTop DUT (
      .CLK, .nRST, .cpuRen, .cpuWen, .halt, .cpuAddr, .cpuStore,
      .cpuHit, .cpuLoad, .flushed,
      .memRen, .memWen, .memAddr, .memStore, .memLoad, .memWait
   );

   task automatic endWithFailure();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic checkWord(input string name, input wordT got, input wordT exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         endWithFailure();
      end
   endtask

   task automatic checkAddr(input string name, input addrT got, input addrT exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         endWithFailure();
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         endWithFailure();
      end
   endtask

   task automatic nextCycle(inout int n, input string what);
      n++;
      if (n > 200)
      begin
         $display("timeout, %s did not happen within 200 cycles", what);
         endWithFailure();
      end
      else
      begin
         @(negedge CLK);
      end
   endtask

   function automatic wordT shadowRead(input logic [29:0] wIdx);
      if (shadow.exists(wIdx))
         return shadow[wIdx];
      return {2'b00, wIdx} ^ 32'hA5A5_0000;
   endfunction

   function automatic addrT mkAddr(input tagT t, input setIdxT s, input logic off);
      return '{tag: t, idx: s, blkOff: off, byteOff: 2'b00};
   endfunction

   // predicts hit, victim write-back and load word, then updates the model
   function automatic wordT refAccess(input addrT a, input logic wr, input wordT st,
                                      output logic expHit, output logic expWb,
                                      output addrT wbAddr);
      setIdxT s;
      logic way;
      s = a.idx;
      expHit = 1'b0;
      expWb = 1'b0;
      wbAddr = '0;
      way = 1'b0;
      if (refValid[0][s] && refTag[0][s] == a.tag)
      begin
         expHit = 1'b1;
      end
      else if (refValid[1][s] && refTag[1][s] == a.tag)
      begin
         expHit = 1'b1;
         way = 1'b1;
      end
      if (expHit)
      begin
         refHits = refHits + 32'd1;
      end
      else
      begin
         way = refLru[s];        // least recently used way goes
         if (refValid[way][s] && refDirty[way][s])
         begin
            expWb = 1'b1;
            wbAddr = mkAddr(refTag[way][s], s, 1'b0);
         end
         refValid[way][s] = 1'b1;
         refTag[way][s] = a.tag;
         refDirty[way][s] = 1'b0;
      end
      refLru[s] = !way;
      if (wr)
      begin
         shadow[a[31:2]] = st;
         refDirty[way][s] = 1'b1;
      end
      return shadowRead(a[31:2]);
   endfunction

   task automatic access(input addrT a, input logic wr, input wordT st);
      wordT expLoad;
      logic expHit;
      logic expWb;
      addrT wbAddr;
      addrT wbAddr1;
      logic sawRen;
      int wrBase;
      int n;
      expLoad = refAccess(a, wr, st, expHit, expWb, wbAddr);
      touched.push_back({a.tag, a.idx, 1'b0});
      touched.push_back({a.tag, a.idx, 1'b1});
      wrBase = wrQ.size();
      n = 0;
      cpuAddr = a;
      cpuStore = st;
      cpuRen = !wr;
      cpuWen = wr;
      @(negedge CLK);
      sawRen = memRen;
      while (!cpuHit)
      begin
         nextCycle(n, "cpuHit");
         sawRen = sawRen | memRen;
      end
      if (!wr)
         checkWord("cpuLoad", cpuLoad, expLoad);
      checkBit("memRen", sawRen, !expHit);
      if (expWb)
      begin
         wbAddr1 = wbAddr;
         wbAddr1.blkOff = 1'b1;
         checkBit("memWen count is 2", wrQ.size() == wrBase + 2, 1'b1);
         checkAddr("memAddr", wrQ[wrBase], wbAddr);
         checkAddr("memAddr", wrQ[wrBase + 1], wbAddr1);
      end
      else
      begin
         checkBit("memWen", wrQ.size() != wrBase, 1'b0);
      end
      cpuRen = 1'b0;
      cpuWen = 1'b0;
      @(negedge CLK);              // next request starts a cycle later
   endtask

   // every committed memory write is compared as it happens
   always @(negedge CLK)
   begin
      if (nRST && memWen && !memWait)
      begin
         wrQ.push_back(memAddr);
         if (halting && !cntSeen)
         begin
            cntSeen = 1'b1;
            checkAddr("memAddr", memAddr, addrT'(`DC_HITCNT_ADDR));
            checkWord("memStore", memStore, refHits);
         end
         else
         begin
            checkWord("memStore", memStore, shadowRead(memAddr[31:2]));
         end
      end
   end

   initial
   begin
      int n;
      int r;
      seed = 17524;
      cpuRen = 1'b0;
      cpuWen = 1'b0;
      halt = 1'b0;
      cpuAddr = '0;
      cpuStore = '0;
      peekAddr = '0;
      halting = 1'b0;
      cntSeen = 1'b0;
      refHits = '0;
      for (int s = 0; s < `DC_SETS; s++)
      begin
         refLru[s] = 1'b0;
         for (int w = 0; w < 2; w++)
         begin
            refValid[w][s] = 1'b0;
            refDirty[w][s] = 1'b0;
            refTag[w][s] = '0;
         end
      end
      n = 0;
      @(negedge CLK);
      while (!nRST)
         nextCycle(n, "reset release");
      checkBit("memRen", memRen, 1'b0);
      checkBit("memWen", memWen, 1'b0);
      checkBit("cpuHit", cpuHit, 1'b0);
      checkBit("flushed", flushed, 1'b0);

      access(mkAddr(5, 1, 0), 1'b0, '0);             // cold read
      access(mkAddr(5, 1, 0), 1'b0, '0);
      access(mkAddr(5, 1, 1), 1'b0, '0);
      access(mkAddr(5, 1, 1), 1'b1, 32'h1111_2222);  // write hit
      access(mkAddr(5, 1, 1), 1'b0, '0);
      access(mkAddr(5, 1, 0), 1'b0, '0);
      access(mkAddr(6, 2, 0), 1'b1, 32'h3333_4444);  // write miss
      access(mkAddr(6, 2, 0), 1'b0, '0);
      access(mkAddr(6, 2, 1), 1'b0, '0);

      access(mkAddr(7, 3, 0), 1'b0, '0);             // LRU order A B A C
      access(mkAddr(8, 3, 0), 1'b0, '0);
      access(mkAddr(7, 3, 0), 1'b0, '0);
      access(mkAddr(9, 3, 0), 1'b0, '0);
      access(mkAddr(7, 3, 1), 1'b0, '0);
      access(mkAddr(8, 3, 1), 1'b0, '0);

      access(mkAddr(10, 4, 0), 1'b1, 32'h5555_6666); // dirty victim
      access(mkAddr(10, 4, 1), 1'b1, 32'h7777_8888);
      access(mkAddr(11, 4, 0), 1'b0, '0);
      access(mkAddr(12, 4, 1), 1'b0, '0);
      access(mkAddr(12, 4, 0), 1'b0, '0);
      access(mkAddr(10, 4, 1), 1'b0, '0);
      access(mkAddr(10, 4, 0), 1'b0, '0);

      for (int i = 0; i < 40; i++)
      begin
         r = $random(seed);
         access(mkAddr(tagT'(20 + r[1:0]), setIdxT'(r[4:2]), r[5]), r[6], $random(seed));
      end

      halting = 1'b1;
      halt = 1'b1;
      n = 0;
      @(negedge CLK);
      while (!flushed)
         nextCycle(n, "flushed");
      checkBit("hit count written", cntSeen, 1'b1);
      repeat (8)
      begin
         @(negedge CLK);
         checkBit("flushed", flushed, 1'b1);
      end
      foreach (touched[i])
      begin
         peekAddr = {touched[i], 2'b00};
         #1;
         checkWord("memory word", peekData, shadowRead(touched[i]));
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
+incdir+src
src/cacheAddrPkg.sv
src/cacheCtrlPkg.sv
src/setStore.sv
src/hitLookup.sv
src/missController.sv
src/dcacheTop.sv
dv/clkGen.sv
dv/memModel.sv
dv/dcacheTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module dcacheTb -f files.f -o simv \
   && ./obj_dir/simv > sim.log 2>&1 \
   || echo "Test failed" >> sim.log
cat sim.log
if grep -q "Test failed" sim.log; then
   exit 1
fi
exit 0
